/* dcache_macros.svh */
// geometry constants for the two-way write-back data cache
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// data and address word width
`define DCACHE_WORD_W 32

// set index for 8 sets
`define DCACHE_IDX_W 3
`define DCACHE_SETS 8

// word minus index, block offset and byte offset
`define DCACHE_TAG_W 26

// two words per block, four bytes per word
`define DCACHE_BLKOFF_W 1
`define DCACHE_BYTOFF_W 2

// flush scan covers both ways of every set plus one done value
`define DCACHE_SCAN_W 5
`define DCACHE_SCAN_LINES 16

`endif

/* dcache_pkg.sv */
// shared types of the data cache for address split, line frame, way commands and FSM states
`default_nettype none

`include "dcache_macros.svh"

package dcache_pkg;

  typedef logic [`DCACHE_WORD_W-1:0] word_t;

  // byte address as seen by the cache
  typedef struct packed {
    logic [`DCACHE_TAG_W-1:0]    tag;
    logic [`DCACHE_IDX_W-1:0]    idx;
    logic [`DCACHE_BLKOFF_W-1:0] blkoff;
    logic [`DCACHE_BYTOFF_W-1:0] bytoff;
  } dcache_addr_t;

  // one cache line
  typedef struct packed {
    logic                     valid;
    logic                     dirty;
    logic [`DCACHE_TAG_W-1:0] tag;
    word_t                    lower;
    word_t                    upper;
  } dcache_frame_t;

  // 0 picks way 0, 1 picks way 1
  typedef logic way_sel_t;

  typedef enum logic [2:0] {
    cmd_none,
    cmd_fill_lower,
    cmd_fill_upper,
    cmd_store_word,
    cmd_clean,
    cmd_touch
  } way_cmd_t;

  typedef enum logic [2:0] {
    st_idle,
    st_wb_lower,
    st_wb_upper,
    st_fill_lower,
    st_fill_upper,
    st_flush_scan,
    st_flushed
  } exec_state_t;

endpackage

`default_nettype wire

/* dcache_decode.sv */
// data cache decode with tag compare on both ways, load word select, hit way and victim choice
`timescale 1ns/100ps
`default_nettype none

module dcache_decode (
  input  wire dcache_pkg::word_t         req_addr,
  input  wire dcache_pkg::dcache_frame_t frame_w0,
  input  wire dcache_pkg::dcache_frame_t frame_w1,
  input  wire dcache_pkg::way_sel_t      lru,
  input  wire dcache_pkg::way_sel_t      wb_way,
  output logic                           tag_hit,
  output dcache_pkg::way_sel_t           hit_way,
  output dcache_pkg::word_t              load_word,
  output dcache_pkg::way_sel_t           victim_way,
  output dcache_pkg::dcache_frame_t      wb_frame
);

  dcache_pkg::dcache_addr_t  addr;
  dcache_pkg::dcache_frame_t hit_frame;
  logic                      hit_w0;
  logic                      hit_w1;

  assign addr = dcache_pkg::dcache_addr_t'(req_addr);

  // only a valid line can match
  assign hit_w0 = frame_w0.valid && (frame_w0.tag == addr.tag);
  assign hit_w1 = frame_w1.valid && (frame_w1.tag == addr.tag);

  assign tag_hit = hit_w0 || hit_w1;
  assign hit_way = hit_w0 ? 1'b0 : 1'b1;

  assign hit_frame = hit_w0 ? frame_w0 : frame_w1;

  // word within the block
  assign load_word = addr.blkoff[0] ? hit_frame.upper : hit_frame.lower;

  // an empty way is used before anything gets evicted
  always_comb
  begin
    if (!frame_w0.valid)
    begin
      victim_way = 1'b0;
    end
    else if (!frame_w1.valid)
    begin
      victim_way = 1'b1;
    end
    else
    begin
      victim_way = lru;
    end
  end

  // line named by execute for miss write-back and flush alike
  assign wb_frame = wb_way ? frame_w1 : frame_w0;

endmodule

`default_nettype wire

/* dcache_ways.sv */
// data cache storage of both ways and the per-set LRU bits with one command per clock
`timescale 1ns/100ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_ways (
  input  wire                            CLK,
  input  wire                            nRST,
  input  wire logic [`DCACHE_IDX_W-1:0]  rd_idx,
  input  wire dcache_pkg::way_cmd_t      cmd,
  input  wire dcache_pkg::way_sel_t      cmd_way,
  input  wire                            cmd_blkoff,
  input  wire logic [`DCACHE_TAG_W-1:0]  cmd_tag,
  input  wire dcache_pkg::word_t         cmd_data,
  output dcache_pkg::dcache_frame_t      frame_w0,
  output dcache_pkg::dcache_frame_t      frame_w1,
  output dcache_pkg::way_sel_t           lru
);

  // valid, dirty and LRU state
  logic [1:0][`DCACHE_SETS-1:0] valid_q;
  logic [1:0][`DCACHE_SETS-1:0] dirty_q;
  logic [`DCACHE_SETS-1:0]      lru_q;

  // tags and data
  logic [`DCACHE_TAG_W-1:0] tag_q   [2][`DCACHE_SETS];
  dcache_pkg::word_t        lower_q [2][`DCACHE_SETS];
  dcache_pkg::word_t        upper_q [2][`DCACHE_SETS];

  dcache_pkg::dcache_frame_t rd_frame [2];

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      valid_q <= '0;
      dirty_q <= '0;
      lru_q   <= '0;
    end
    else
    begin
      case (cmd)
        dcache_pkg::cmd_fill_upper:
        begin
          valid_q[cmd_way][rd_idx] <= 1'b1;
        end
        dcache_pkg::cmd_store_word:
        begin
          dirty_q[cmd_way][rd_idx] <= 1'b1;
          lru_q[rd_idx]            <= ~cmd_way;
        end
        dcache_pkg::cmd_clean:
        begin
          dirty_q[cmd_way][rd_idx] <= 1'b0;
        end
        // the other way becomes least recent
        dcache_pkg::cmd_touch:
        begin
          lru_q[rd_idx] <= ~cmd_way;
        end
        default:
        begin
        end
      endcase
    end
  end

  always_ff @(posedge CLK)
  begin
    case (cmd)
      dcache_pkg::cmd_fill_lower:
      begin
        lower_q[cmd_way][rd_idx] <= cmd_data;
        tag_q[cmd_way][rd_idx]   <= cmd_tag;
      end
      dcache_pkg::cmd_fill_upper:
      begin
        upper_q[cmd_way][rd_idx] <= cmd_data;
      end
      dcache_pkg::cmd_store_word:
      begin
        if (cmd_blkoff)
        begin
          upper_q[cmd_way][rd_idx] <= cmd_data;
        end
        else
        begin
          lower_q[cmd_way][rd_idx] <= cmd_data;
        end
      end
      default:
      begin
      end
    endcase
  end

  // both frames of the addressed set
  always_comb
  begin
    for (int w = 0; w < 2; w++)
    begin
      rd_frame[w].valid = valid_q[w][rd_idx];
      rd_frame[w].dirty = dirty_q[w][rd_idx];
      rd_frame[w].tag   = tag_q[w][rd_idx];
      rd_frame[w].lower = lower_q[w][rd_idx];
      rd_frame[w].upper = upper_q[w][rd_idx];
    end
  end

  assign frame_w0 = rd_frame[0];
  assign frame_w1 = rd_frame[1];
  assign lru      = lru_q[rd_idx];

endmodule

`default_nettype wire

/* dcache_execute.sv */
// data cache controller FSM for miss handling, dirty write-back, block fill and halt flush
`timescale 1ns/100ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_execute (
  input  wire                            CLK,
  input  wire                            nRST,
  input  wire                            dmemREN,
  input  wire                            dmemWEN,
  input  wire                            halt,
  input  wire dcache_pkg::word_t         dmemaddr,
  input  wire dcache_pkg::word_t         dmemstore,
  input  wire                            tag_hit,
  input  wire dcache_pkg::way_sel_t      hit_way,
  input  wire dcache_pkg::way_sel_t      victim_way,
  input  wire dcache_pkg::dcache_frame_t wb_frame,
  input  wire                            dwait,
  input  wire dcache_pkg::word_t         dload,
  output logic [`DCACHE_IDX_W-1:0]       rd_idx,
  output dcache_pkg::way_cmd_t           cmd,
  output dcache_pkg::way_sel_t           cmd_way,
  output logic                           cmd_blkoff,
  output logic [`DCACHE_TAG_W-1:0]       cmd_tag,
  output dcache_pkg::word_t              cmd_data,
  output dcache_pkg::way_sel_t           wb_way,
  output logic                           dhit,
  output logic                           flushed,
  output logic                           dREN,
  output logic                           dWEN,
  output dcache_pkg::word_t              daddr,
  output dcache_pkg::word_t              dstore
);

  dcache_pkg::exec_state_t  state_q;
  dcache_pkg::exec_state_t  state_d;
  logic [`DCACHE_SCAN_W-1:0] scan_q;
  logic [`DCACHE_SCAN_W-1:0] scan_d;
  dcache_pkg::way_sel_t     victim_q;
  dcache_pkg::way_sel_t     victim_d;
  logic                     flush_q;
  logic                     flush_d;

  dcache_pkg::dcache_addr_t req;
  dcache_pkg::dcache_addr_t mem_addr;
  logic                     request;
  logic                     in_wb;
  logic                     in_fill;
  logic                     scan_done;

  assign req       = dcache_pkg::dcache_addr_t'(dmemaddr);
  assign request   = dmemREN || dmemWEN;
  assign in_wb     = (state_q == dcache_pkg::st_wb_lower) || (state_q == dcache_pkg::st_wb_upper);
  assign in_fill   = (state_q == dcache_pkg::st_fill_lower) ||
                     (state_q == dcache_pkg::st_fill_upper);
  assign scan_done = (scan_q == `DCACHE_SCAN_W'(`DCACHE_SCAN_LINES));

  // flush walks way 0 sets 0..7, then way 1 sets 0..7
  assign rd_idx = flush_q ? scan_q[`DCACHE_IDX_W-1:0] : req.idx;

  // in idle the candidate victim is shown so its dirty bit can be seen
  assign wb_way = flush_q ? scan_q[`DCACHE_IDX_W] :
                  ((state_q == dcache_pkg::st_idle) ? victim_way : victim_q);

  assign cmd_blkoff = req.blkoff[0];
  assign cmd_tag    = req.tag;

  assign dhit    = (state_q == dcache_pkg::st_idle) && !halt && request && tag_hit;
  assign flushed = (state_q == dcache_pkg::st_flushed);

  // block aligned memory address with the upper word in the second state of each pair
  always_comb
  begin
    mem_addr.tag    = in_wb ? wb_frame.tag : req.tag;
    mem_addr.idx    = rd_idx;
    mem_addr.blkoff = ((state_q == dcache_pkg::st_wb_upper) ||
                       (state_q == dcache_pkg::st_fill_upper)) ? 1'b1 : 1'b0;
    mem_addr.bytoff = '0;
  end

  assign daddr  = mem_addr;
  assign dstore = (state_q == dcache_pkg::st_wb_upper) ? wb_frame.upper : wb_frame.lower;
  assign dREN   = in_fill;
  assign dWEN   = in_wb;

  always_comb
  begin
    state_d  = state_q;
    scan_d   = scan_q;
    victim_d = victim_q;
    flush_d  = flush_q;
    cmd      = dcache_pkg::cmd_none;
    cmd_way  = wb_way;
    cmd_data = dload;
    case (state_q)
      dcache_pkg::st_idle:
      begin
        if (halt)
        begin
          state_d = dcache_pkg::st_flush_scan;
          flush_d = 1'b1;
          scan_d  = '0;
        end
        else if (request && tag_hit)
        begin
          cmd_way  = hit_way;
          cmd_data = dmemstore;
          if (dmemWEN)
          begin
            cmd = dcache_pkg::cmd_store_word;
          end
          else
          begin
            cmd = dcache_pkg::cmd_touch;
          end
        end
        else if (request)
        begin
          victim_d = victim_way;
          if (wb_frame.valid && wb_frame.dirty)
          begin
            state_d = dcache_pkg::st_wb_lower;
          end
          else
          begin
            state_d = dcache_pkg::st_fill_lower;
          end
        end
      end
      dcache_pkg::st_wb_lower:
      begin
        if (!dwait)
        begin
          state_d = dcache_pkg::st_wb_upper;
        end
      end
      dcache_pkg::st_wb_upper:
      begin
        if (!dwait)
        begin
          cmd = dcache_pkg::cmd_clean;
          if (flush_q)
          begin
            state_d = dcache_pkg::st_flush_scan;
            scan_d  = scan_q + `DCACHE_SCAN_W'(1);
          end
          else
          begin
            state_d = dcache_pkg::st_fill_lower;
          end
        end
      end
      dcache_pkg::st_fill_lower:
      begin
        if (!dwait)
        begin
          cmd     = dcache_pkg::cmd_fill_lower;
          state_d = dcache_pkg::st_fill_upper;
        end
      end
      // the pending request hits once back in idle
      dcache_pkg::st_fill_upper:
      begin
        if (!dwait)
        begin
          cmd     = dcache_pkg::cmd_fill_upper;
          state_d = dcache_pkg::st_idle;
        end
      end
      dcache_pkg::st_flush_scan:
      begin
        if (scan_done)
        begin
          state_d = dcache_pkg::st_flushed;
        end
        else if (wb_frame.valid && wb_frame.dirty)
        begin
          state_d = dcache_pkg::st_wb_lower;
        end
        else
        begin
          scan_d = scan_q + `DCACHE_SCAN_W'(1);
        end
      end
      // stays here until reset
      dcache_pkg::st_flushed:
      begin
        state_d = dcache_pkg::st_flushed;
      end
      default:
      begin
        state_d = dcache_pkg::st_idle;
      end
    endcase
  end

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      state_q  <= dcache_pkg::st_idle;
      scan_q   <= '0;
      victim_q <= 1'b0;
      flush_q  <= 1'b0;
    end
    else
    begin
      state_q  <= state_d;
      scan_q   <= scan_d;
      victim_q <= victim_d;
      flush_q  <= flush_d;
    end
  end

endmodule

`default_nettype wire

/* dcache_top.sv */
// two-way write-back data cache between the datapath and a word-wide memory port
`timescale 1ns/100ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_top (
  input  wire                    CLK,
  input  wire                    nRST,
  input  wire                    dmemREN,
  input  wire                    dmemWEN,
  input  wire dcache_pkg::word_t dmemaddr,
  input  wire dcache_pkg::word_t dmemstore,
  input  wire                    halt,
  output dcache_pkg::word_t      dmemload,
  output logic                   dhit,
  output logic                   flushed,
  output logic                   dREN,
  output logic                   dWEN,
  output dcache_pkg::word_t      daddr,
  output dcache_pkg::word_t      dstore,
  input  wire dcache_pkg::word_t dload,
  input  wire                    dwait
);

  // execute to ways
  logic [`DCACHE_IDX_W-1:0]  rd_idx;
  dcache_pkg::way_cmd_t      cmd;
  dcache_pkg::way_sel_t      cmd_way;
  logic                      cmd_blkoff;
  logic [`DCACHE_TAG_W-1:0]  cmd_tag;
  dcache_pkg::word_t         cmd_data;

  // ways to decode
  dcache_pkg::dcache_frame_t frame_w0;
  dcache_pkg::dcache_frame_t frame_w1;
  dcache_pkg::way_sel_t      lru;

  // decode and execute
  dcache_pkg::way_sel_t      wb_way;
  logic                      tag_hit;
  dcache_pkg::way_sel_t      hit_way;
  dcache_pkg::way_sel_t      victim_way;
  dcache_pkg::dcache_frame_t wb_frame;

  dcache_decode u_decode (
    .req_addr   (dmemaddr),
    .frame_w0   (frame_w0),
    .frame_w1   (frame_w1),
    .lru        (lru),
    .wb_way     (wb_way),
    .tag_hit    (tag_hit),
    .hit_way    (hit_way),
    .load_word  (dmemload),
    .victim_way (victim_way),
    .wb_frame   (wb_frame)
  );

  dcache_ways u_ways (
    .CLK        (CLK),
    .nRST       (nRST),
    .rd_idx     (rd_idx),
    .cmd        (cmd),
    .cmd_way    (cmd_way),
    .cmd_blkoff (cmd_blkoff),
    .cmd_tag    (cmd_tag),
    .cmd_data   (cmd_data),
    .frame_w0   (frame_w0),
    .frame_w1   (frame_w1),
    .lru        (lru)
  );

  dcache_execute u_execute (
    .CLK        (CLK),
    .nRST       (nRST),
    .dmemREN    (dmemREN),
    .dmemWEN    (dmemWEN),
    .halt       (halt),
    .dmemaddr   (dmemaddr),
    .dmemstore  (dmemstore),
    .tag_hit    (tag_hit),
    .hit_way    (hit_way),
    .victim_way (victim_way),
    .wb_frame   (wb_frame),
    .dwait      (dwait),
    .dload      (dload),
    .rd_idx     (rd_idx),
    .cmd        (cmd),
    .cmd_way    (cmd_way),
    .cmd_blkoff (cmd_blkoff),
    .cmd_tag    (cmd_tag),
    .cmd_data   (cmd_data),
    .wb_way     (wb_way),
    .dhit       (dhit),
    .flushed    (flushed),
    .dREN       (dREN),
    .dWEN       (dWEN),
    .daddr      (daddr),
    .dstore     (dstore)
  );

endmodule

`default_nettype wire

/* tb_dcache_mem.sv */
// word memory model for the data cache testbench with a fixed wait on every transfer
`timescale 1ns/100ps
`default_nettype none

module tb_dcache_mem #(
  parameter dcache_pkg::word_t PATTERN = 32'hA5C3_0F00
) (
  input  wire                    CLK,
  input  wire                    nRST,
  input  wire                    dREN,
  input  wire                    dWEN,
  input  wire dcache_pkg::word_t daddr,
  input  wire dcache_pkg::word_t dstore,
  output dcache_pkg::word_t      dload,
  output logic                   dwait
);

  localparam int DEPTH = 256;
  localparam logic [1:0] WAIT_CYCLES = 2'd2;

  // byte addresses 0x000 to 0x3ff in words
  dcache_pkg::word_t words [DEPTH];
  logic [1:0]        wait_cnt;
  logic              busy;

  initial
  begin
    for (int i = 0; i < DEPTH; i++)
    begin
      words[i] = dcache_pkg::word_t'(i << 2) ^ PATTERN;
    end
  end

  assign busy  = dREN || dWEN;
  assign dwait = !(busy && (wait_cnt == WAIT_CYCLES));
  assign dload = words[daddr[9:2]];

  // counts the wait cycles of the transfer in progress
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      wait_cnt <= '0;
    end
    else if (busy && dwait)
    begin
      wait_cnt <= wait_cnt + 2'd1;
    end
    else
    begin
      wait_cnt <= '0;
    end
  end

  always @(posedge CLK)
  begin
    if (dWEN && !dwait)
    begin
      words[daddr[9:2]] <= dstore;
    end
  end

endmodule

`default_nettype wire

/* tb_dcache.sv */
// testbench for the two-way data cache with a table of accesses, a reference model and a flush
`timescale 1ns/100ps
`default_nettype none

`include "dcache_macros.svh"

module tb_dcache;

  localparam dcache_pkg::word_t MEM_PATTERN = 32'hA5C3_0F00;
  localparam logic [1:0] OP_LOAD = 2'd0;
  localparam logic [1:0] OP_STORE = 2'd1;
  localparam logic [1:0] OP_HALT = 2'd2;

  typedef struct packed {
    logic [1:0]        op;
    dcache_pkg::word_t addr;
    dcache_pkg::word_t data;
    dcache_pkg::word_t exp_load;
    logic              exp_fill;
    logic              exp_wb;
    dcache_pkg::word_t wb_addr;
    dcache_pkg::word_t wb_lo;
    dcache_pkg::word_t wb_hi;
  } row_t;

  logic              CLK;
  logic              nRST;
  logic              dmemREN;
  logic              dmemWEN;
  dcache_pkg::word_t dmemaddr;
  dcache_pkg::word_t dmemstore;
  logic              halt;
  dcache_pkg::word_t dmemload;
  logic              dhit;
  logic              flushed;
  logic              dREN;
  logic              dWEN;
  dcache_pkg::word_t daddr;
  dcache_pkg::word_t dstore;
  dcache_pkg::word_t dload;
  logic              dwait;

  // reference model of a flat word map plus tags, dirty and LRU per set
  dcache_pkg::word_t        ref_mem [256];
  logic                     m_valid [2][`DCACHE_SETS];
  logic                     m_dirty [2][`DCACHE_SETS];
  logic [`DCACHE_TAG_W-1:0] m_tag   [2][`DCACHE_SETS];
  logic                     m_lru   [`DCACHE_SETS];

  row_t              table_q [$];
  dcache_pkg::word_t stored_q [$];
  dcache_pkg::word_t lcg_state = 32'd8;
  dcache_pkg::word_t last_wb_addr = '0;
  int                rd_total = 0;
  int                wr_total = 0;
  int                checks = 0;
  int                errors = 0;
  logic              built = 1'b0;

  dcache_top u_dcache_top (
    .CLK       (CLK),
    .nRST      (nRST),
    .dmemREN   (dmemREN),
    .dmemWEN   (dmemWEN),
    .dmemaddr  (dmemaddr),
    .dmemstore (dmemstore),
    .halt      (halt),
    .dmemload  (dmemload),
    .dhit      (dhit),
    .flushed   (flushed),
    .dREN      (dREN),
    .dWEN      (dWEN),
    .daddr     (daddr),
    .dstore    (dstore),
    .dload     (dload),
    .dwait     (dwait)
  );

  tb_dcache_mem #(.PATTERN(MEM_PATTERN)) u_mem (
    .CLK    (CLK),
    .nRST   (nRST),
    .dREN   (dREN),
    .dWEN   (dWEN),
    .daddr  (daddr),
    .dstore (dstore),
    .dload  (dload),
    .dwait  (dwait)
  );

  initial
  begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  // memory traffic sampled mid cycle
  always @(negedge CLK)
  begin
    if (dREN && !dwait)
    begin
      rd_total = rd_total + 1;
    end
    if (dWEN && !dwait)
    begin
      wr_total = wr_total + 1;
      if (!daddr[2])
      begin
        last_wb_addr = daddr;
      end
    end
  end

  function automatic dcache_pkg::word_t lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic dcache_pkg::word_t mem_word(input dcache_pkg::word_t addr);
    return u_mem.words[addr[9:2]];
  endfunction

  task automatic check_word(input string name, input dcache_pkg::word_t got,
                            input dcache_pkg::word_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  // predicts one access from the model state and updates the model
  task automatic add_row(input logic [1:0] op, input dcache_pkg::word_t addr);
    row_t                     r;
    logic [`DCACHE_IDX_W-1:0] s;
    logic [`DCACHE_TAG_W-1:0] tag;
    dcache_pkg::way_sel_t     w;
    r = '0;
    r.op = op;
    r.addr = addr;
    s = addr[5:3];
    tag = addr[31:6];
    if (op != OP_HALT)
    begin
      if (m_valid[0][s] && (m_tag[0][s] == tag))
      begin
        w = 1'b0;
      end
      else if (m_valid[1][s] && (m_tag[1][s] == tag))
      begin
        w = 1'b1;
      end
      else
      begin
        r.exp_fill = 1'b1;
        w = !m_valid[0][s] ? 1'b0 : (!m_valid[1][s] ? 1'b1 : m_lru[s]);
        if (m_valid[w][s] && m_dirty[w][s])
        begin
          r.exp_wb = 1'b1;
          r.wb_addr = {m_tag[w][s], s, 3'b000};
          r.wb_lo = ref_mem[r.wb_addr[9:2]];
          r.wb_hi = ref_mem[r.wb_addr[9:2] + 8'd1];
        end
        m_valid[w][s] = 1'b1;
        m_dirty[w][s] = 1'b0;
        m_tag[w][s] = tag;
      end
      if (op == OP_STORE)
      begin
        r.data = lcg_next();
        ref_mem[addr[9:2]] = r.data;
        m_dirty[w][s] = 1'b1;
        stored_q.push_back(addr);
      end
      m_lru[s] = ~w;
      r.exp_load = ref_mem[addr[9:2]];
    end
    table_q.push_back(r);
  endtask

  task automatic build_table();
    for (int i = 0; i < 256; i++)
    begin
      ref_mem[i] = dcache_pkg::word_t'(i << 2) ^ MEM_PATTERN;
    end
    for (int i = 0; i < `DCACHE_SETS; i++)
    begin
      m_valid[0][i] = 1'b0;
      m_valid[1][i] = 1'b0;
      m_dirty[0][i] = 1'b0;
      m_dirty[1][i] = 1'b0;
      m_lru[i] = 1'b0;
    end
    // set 0 gets a cold miss, both words and a store hit
    add_row(OP_LOAD, 32'h0000_0100);
    add_row(OP_LOAD, 32'h0000_0104);
    add_row(OP_LOAD, 32'h0000_0100);
    add_row(OP_STORE, 32'h0000_0104);
    add_row(OP_LOAD, 32'h0000_0104);
    // store miss allocates
    add_row(OP_STORE, 32'h0000_0210);
    add_row(OP_LOAD, 32'h0000_0210);
    // in set 1 C evicts dirty B once A is loaded again
    add_row(OP_LOAD, 32'h0000_0008);
    add_row(OP_STORE, 32'h0000_004C);
    add_row(OP_LOAD, 32'h0000_000C);
    add_row(OP_LOAD, 32'h0000_0088);
    add_row(OP_LOAD, 32'h0000_0008);
    add_row(OP_LOAD, 32'h0000_004C);
    // set 3 stored block pushed out by two other tags
    add_row(OP_STORE, 32'h0000_0018);
    add_row(OP_LOAD, 32'h0000_0058);
    add_row(OP_LOAD, 32'h0000_0098);
    add_row(OP_LOAD, 32'h0000_0018);
    // left dirty for the flush
    add_row(OP_STORE, 32'h0000_02EC);
    add_row(OP_STORE, 32'h0000_03F8);
    add_row(OP_STORE, 32'h0000_01F8);
    add_row(OP_HALT, 32'h0000_0000);
  endtask

  task automatic apply_row(input row_t r);
    int rd0;
    int wr0;
    @(posedge CLK);
    #5;
    rd0 = rd_total;
    wr0 = wr_total;
    if (r.op == OP_HALT)
    begin
      halt = 1'b1;
      do @(negedge CLK); while (!flushed);
      repeat (3)
      begin
        @(negedge CLK);
        check_flag("flushed", flushed, 1'b1);
      end
    end
    else
    begin
      dmemaddr = r.addr;
      dmemstore = r.data;
      dmemREN = (r.op == OP_LOAD);
      dmemWEN = (r.op == OP_STORE);
      do @(negedge CLK); while (!dhit);
      if (r.op == OP_LOAD)
      begin
        check_word("dmemload", dmemload, r.exp_load);
      end
      check_word("fill transfers", rd_total - rd0, r.exp_fill ? 2 : 0);
      check_flag("dirty writeback", wr_total != wr0, r.exp_wb);
      if (r.exp_wb)
      begin
        check_word("writeback daddr", last_wb_addr, r.wb_addr);
        check_word("memory lower word", mem_word(r.wb_addr), r.wb_lo);
        check_word("memory upper word", mem_word(r.wb_addr + 32'd4), r.wb_hi);
      end
      @(posedge CLK);
      #5;
      dmemREN = 1'b0;
      dmemWEN = 1'b0;
    end
  endtask

  initial
  begin
    nRST = 1'b0;
    dmemREN = 1'b0;
    dmemWEN = 1'b0;
    dmemaddr = '0;
    dmemstore = '0;
    halt = 1'b0;
    build_table();
    built = 1'b1;
    repeat (4) @(posedge CLK);
    #5;
    nRST = 1'b1;
    @(negedge CLK);
    check_flag("flushed", flushed, 1'b0);
    check_flag("dhit", dhit, 1'b0);
    check_flag("dREN", dREN, 1'b0);
    check_flag("dWEN", dWEN, 1'b0);
    foreach (table_q[i])
    begin
      apply_row(table_q[i]);
    end
    // everything stored must have reached memory
    foreach (stored_q[i])
    begin
      check_word("memory word", mem_word(stored_q[i]), ref_mem[stored_q[i][9:2]]);
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
    begin
      $display("TEST RESULT: PASS");
    end
    else
    begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // 200 cycles per table row plus reset
  initial
  begin
    wait (built);
    repeat (table_q.size() * 200 + 20) @(posedge CLK);
    $display("timeout: the cache did not finish the table in time");
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+.
dcache_pkg.sv
dcache_decode.sv
dcache_ways.sv
dcache_execute.sv
dcache_top.sv
tb_dcache_mem.sv
tb_dcache.sv

/* run.sh */
#!/bin/sh
# compile and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module tb_dcache -o tb_dcache_sim
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/tb_dcache_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
  exit 1
fi
exit 0
